//--- all.f
+incdir+include
rtl/mcpu_pkg.sv
rtl/mcpu_ctrl.sv
rtl/mcpu_fetch.sv
rtl/mcpu_decode.sv
rtl/mcpu_regfile.sv
rtl/mcpu_alu.sv
rtl/mcpu_top.sv
tests/mcpu_clk_gen.sv
tests/mcpu_props.sv
tests/mcpu_tb.sv

//--- include/mcpu_consts.svh
`ifndef MCPU_CONSTS_SVH
`define MCPU_CONSTS_SVH

// first fetch address out of reset
`define MCPU_RESET_PC 32'h1c00_0000

// datapath and address width
`define MCPU_XLEN 32

// general register file
`define MCPU_NREGS 32
`define MCPU_RADDR_W 5

`endif

//--- rtl/mcpu_alu.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module mcpu_alu (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  op_load,
    input  logic                  res_load,
    input  mcpu_pkg::alu_op_t     alu_op,
    input  logic                  src1_is_pc,
    input  logic                  src2_is_imm,
    input  logic [`MCPU_XLEN-1:0] pc,
    input  logic [`MCPU_XLEN-1:0] rj_value,
    input  logic [`MCPU_XLEN-1:0] rkd_value,
    input  logic [`MCPU_XLEN-1:0] imm,
    output logic [`MCPU_XLEN-1:0] alu_result
);
    import mcpu_pkg::*;

    logic [`MCPU_XLEN-1:0] src1;
    logic [`MCPU_XLEN-1:0] src2;
    logic [`MCPU_XLEN-1:0] result;
    logic [4:0]            shamt;

    always_ff @(posedge clk) begin
        if (op_load) begin
            src1 <= src1_is_pc ? pc : rj_value;
            src2 <= src2_is_imm ? imm : rkd_value;
        end
    end

    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'b0, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $signed(src1) >>> shamt;  // sign fill
            ALU_LUI:  result = src2;
            default:  result = src1 + src2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_result <= '0;
        end else if (res_load) begin
            alu_result <= result;
        end
    end

endmodule

//--- rtl/mcpu_ctrl.sv
`timescale 1ns/1ps

module mcpu_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  logic             is_branch_only,
    input  logic             is_load,
    input  logic             is_store,
    input  logic             reg_write,
    output mcpu_pkg::state_t state,
    output logic             ir_load,
    output logic             op_load,
    output logic             res_load,
    output logic             data_we,
    output logic             rf_we,
    output logic             pc_load
);
    import mcpu_pkg::*;

    state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IF;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            S_IF:    next_state = S_ID;
            S_ID:    next_state = is_branch_only ? S_IF : S_EXE;
            S_EXE:   next_state = (is_load || is_store) ? S_MEM : S_WB;
            S_MEM:   next_state = is_load ? S_WB : S_IF;  // store ends here
            S_WB:    next_state = S_IF;
            default: next_state = S_IF;
        endcase
    end

    assign ir_load  = (state == S_ID);
    assign op_load  = (state == S_ID);  // operands and next pc
    assign res_load = (state == S_EXE);
    assign data_we  = (state == S_MEM) && is_store;
    assign rf_we    = (state == S_WB) && reg_write;

    // last state of any instruction
    assign pc_load  = (state != S_IF) && (next_state == S_IF);

endmodule

//--- rtl/mcpu_decode.sv
`timescale 1ns/1ps

module mcpu_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               ir_load,
    input  logic [31:0]        inst_sram_rdata,
    output logic [4:0]         rf_raddr1,
    output logic [4:0]         rf_raddr2,
    output logic [4:0]         rf_waddr,
    output mcpu_pkg::alu_op_t  alu_op,
    output logic [31:0]        imm,
    output logic [31:0]        br_offs,
    output logic [1:0]         br_kind,
    output logic               is_jirl,
    output logic               src1_is_pc,
    output logic               src2_is_imm,
    output logic               is_branch_only,
    output logic               is_load,
    output logic               is_store,
    output logic               reg_write
);
    import mcpu_pkg::*;

    logic [31:0] ir;
    logic [31:0] inst;
    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic        grp_3r;
    logic        grp_shift;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic        inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic        src2_is_4;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= inst_sram_rdata;
        end
    end

    assign inst = ir_load ? inst_sram_rdata : ir;  // bypass in ID

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign grp_3r    = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign grp_shift = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = grp_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = grp_3r && (op_19_15 == 5'h02);
    assign inst_slt     = grp_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = grp_3r && (op_19_15 == 5'h05);
    assign inst_nor     = grp_3r && (op_19_15 == 5'h08);
    assign inst_and     = grp_3r && (op_19_15 == 5'h09);
    assign inst_or      = grp_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = grp_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = grp_shift && (op_19_15 == 5'h01);
    assign inst_srli_w  = grp_shift && (op_19_15 == 5'h09);
    assign inst_srai_w  = grp_shift && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];

    always_comb begin
        case (1'b1)
            inst_sub_w:   alu_op = ALU_SUB;
            inst_slt:     alu_op = ALU_SLT;
            inst_sltu:    alu_op = ALU_SLTU;
            inst_and:     alu_op = ALU_AND;
            inst_nor:     alu_op = ALU_NOR;
            inst_or:      alu_op = ALU_OR;
            inst_xor:     alu_op = ALU_XOR;
            inst_slli_w:  alu_op = ALU_SLL;
            inst_srli_w:  alu_op = ALU_SRL;
            inst_srai_w:  alu_op = ALU_SRA;
            inst_lu12i_w: alu_op = ALU_LUI;
            default:      alu_op = ALU_ADD;
        endcase
    end

    assign src2_is_4 = inst_jirl || inst_bl;  // link = pc + 4 through the alu

    always_comb begin
        if (src2_is_4) begin
            imm = 32'd4;
        end else if (inst_lu12i_w) begin
            imm = {inst[24:5], 12'b0};
        end else if (grp_shift) begin
            imm = {27'b0, inst[14:10]};  // ui5
        end else begin
            imm = {{20{inst[21]}}, inst[21:10]};
        end
    end

    assign br_offs = (inst_b || inst_bl) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                         : {{14{inst[25]}}, inst[25:10], 2'b0};

    assign br_kind = (inst_b || inst_bl || inst_jirl) ? 2'd1 :
                     inst_beq                         ? 2'd2 :
                     inst_bne                         ? 2'd3 : 2'd0;

    assign is_jirl   = inst_jirl;
    assign rf_raddr1 = inst[9:5];
    assign rf_raddr2 = (inst_beq || inst_bne || inst_st_w) ? inst[4:0] : inst[14:10];
    assign rf_waddr  = inst_bl ? 5'd1 : inst[4:0];

    assign src1_is_pc  = src2_is_4;
    assign src2_is_imm = grp_shift || inst_addi_w || inst_lu12i_w || inst_ld_w
                      || inst_st_w || src2_is_4;

    assign is_branch_only = inst_b || inst_beq || inst_bne;
    assign is_load        = inst_ld_w;
    assign is_store       = inst_st_w;

    // unknown opcodes fall out here as no-ops
    assign reg_write = inst_add_w || inst_sub_w || inst_slt || inst_sltu || inst_nor
                    || inst_and || inst_or || inst_xor || inst_slli_w || inst_srli_w
                    || inst_srai_w || inst_addi_w || inst_lu12i_w || inst_ld_w
                    || inst_jirl || inst_bl;

endmodule

//--- rtl/mcpu_fetch.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module mcpu_fetch (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  op_load,
    input  logic                  pc_load,
    input  logic [1:0]            br_kind,  // none, uncond, eq, ne
    input  logic                  is_jirl,
    input  logic [`MCPU_XLEN-1:0] rj_value,
    input  logic [`MCPU_XLEN-1:0] rkd_value,
    input  logic [`MCPU_XLEN-1:0] br_offs,
    output logic [`MCPU_XLEN-1:0] pc,
    output logic [`MCPU_XLEN-1:0] link_pc
);
    logic                  taken;
    logic [`MCPU_XLEN-1:0] br_target;
    logic [`MCPU_XLEN-1:0] next_pc;
    logic [`MCPU_XLEN-1:0] next_pc_q;

    always_comb begin
        case (br_kind)
            2'd1:    taken = 1'b1;
            2'd2:    taken = (rj_value == rkd_value);
            2'd3:    taken = (rj_value != rkd_value);
            default: taken = 1'b0;
        endcase
    end

    assign link_pc   = pc + 32'd4;
    assign br_target = (is_jirl ? rj_value : pc) + br_offs;
    assign next_pc   = taken ? br_target : link_pc;

    always_ff @(posedge clk) begin
        if (op_load) begin
            next_pc_q <= next_pc;
        end
    end

    // branches finish in ID, so take the live value then
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MCPU_RESET_PC;
        end else if (pc_load) begin
            pc <= op_load ? next_pc : next_pc_q;
        end
    end

endmodule

//--- rtl/mcpu_pkg.sv
package mcpu_pkg;

    // one instruction at a time, states skipped when not needed
    typedef enum logic [2:0] {
        S_IF  = 3'd0,
        S_ID  = 3'd1,
        S_EXE = 3'd2,
        S_MEM = 3'd3,
        S_WB  = 3'd4
    } state_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,  // also address and link calc
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11  // passes src2 through
    } alu_op_t;

endpackage

//--- rtl/mcpu_regfile.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module mcpu_regfile (
    input  logic                     clk,
    input  logic [`MCPU_RADDR_W-1:0] raddr1,
    input  logic [`MCPU_RADDR_W-1:0] raddr2,
    input  logic                     we,
    input  logic [`MCPU_RADDR_W-1:0] waddr,
    input  logic [`MCPU_XLEN-1:0]    wdata,
    output logic [`MCPU_XLEN-1:0]    rdata1,
    output logic [`MCPU_XLEN-1:0]    rdata2
);
    logic [`MCPU_XLEN-1:0] regs [`MCPU_NREGS];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin  // r0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- rtl/mcpu_top.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module mcpu_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`MCPU_XLEN-1:0]    inst_sram_rdata,
    input  logic [`MCPU_XLEN-1:0]    data_sram_rdata,
    output logic [`MCPU_XLEN-1:0]    inst_sram_addr,
    output logic                     data_sram_we,
    output logic [`MCPU_XLEN-1:0]    data_sram_addr,
    output logic [`MCPU_XLEN-1:0]    data_sram_wdata,
    output logic [`MCPU_XLEN-1:0]    debug_wb_pc,
    output logic [3:0]               debug_wb_rf_we,
    output logic [`MCPU_RADDR_W-1:0] debug_wb_rf_wnum,
    output logic [`MCPU_XLEN-1:0]    debug_wb_rf_wdata
);
    import mcpu_pkg::*;

    logic                     ir_load, op_load, res_load, data_we, rf_we, pc_load;
    logic                     is_branch_only, is_load, is_store, reg_write;
    logic [`MCPU_RADDR_W-1:0] rf_raddr1, rf_raddr2, rf_waddr;
    logic [`MCPU_XLEN-1:0]    rj_value, rkd_value, wb_data;
    logic [`MCPU_XLEN-1:0]    pc, imm, br_offs, alu_result;
    logic [1:0]               br_kind;
    logic                     is_jirl, src1_is_pc, src2_is_imm;
    alu_op_t                  alu_op;

    mcpu_ctrl mcpu_ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .is_branch_only (is_branch_only),
        .is_load        (is_load),
        .is_store       (is_store),
        .reg_write      (reg_write),
        .state          (),
        .ir_load        (ir_load),
        .op_load        (op_load),
        .res_load       (res_load),
        .data_we        (data_we),
        .rf_we          (rf_we),
        .pc_load        (pc_load)
    );

    mcpu_fetch mcpu_fetch_i (
        .clk       (clk),
        .reset     (reset),
        .op_load   (op_load),
        .pc_load   (pc_load),
        .br_kind   (br_kind),
        .is_jirl   (is_jirl),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (br_offs),
        .pc        (pc),
        .link_pc   ()  // link goes through the alu
    );

    mcpu_decode mcpu_decode_i (
        .clk             (clk),
        .reset           (reset),
        .ir_load         (ir_load),
        .inst_sram_rdata (inst_sram_rdata),
        .rf_raddr1       (rf_raddr1),
        .rf_raddr2       (rf_raddr2),
        .rf_waddr        (rf_waddr),
        .alu_op          (alu_op),
        .imm             (imm),
        .br_offs         (br_offs),
        .br_kind         (br_kind),
        .is_jirl         (is_jirl),
        .src1_is_pc      (src1_is_pc),
        .src2_is_imm     (src2_is_imm),
        .is_branch_only  (is_branch_only),
        .is_load         (is_load),
        .is_store        (is_store),
        .reg_write       (reg_write)
    );

    mcpu_regfile mcpu_regfile_i (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (wb_data),
        .rdata1 (rj_value),
        .rdata2 (rkd_value)
    );

    mcpu_alu mcpu_alu_i (
        .clk         (clk),
        .reset       (reset),
        .op_load     (op_load),
        .res_load    (res_load),
        .alu_op      (alu_op),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .pc          (pc),
        .rj_value    (rj_value),
        .rkd_value   (rkd_value),
        .imm         (imm),
        .alu_result  (alu_result)
    );

    assign inst_sram_addr  = pc;
    assign data_sram_we    = data_we;
    assign data_sram_addr  = alu_result;  // held since EXE
    assign data_sram_wdata = rkd_value;

    assign wb_data = is_load ? data_sram_rdata : alu_result;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = wb_data;

endmodule

//--- tests/mcpu_clk_gen.sv
`timescale 1ns/1ps

module mcpu_clk_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- tests/mcpu_props.sv
`timescale 1ns/1ps

module mcpu_props (
    input logic             clk,
    input logic             reset,
    input mcpu_pkg::state_t state,
    input logic             ir_load,
    input logic             pc_load,
    input logic             data_we,
    input logic             is_branch_only,
    input logic             is_store
);
    import mcpu_pkg::*;

    id_after_if: assert property (@(posedge clk) disable iff (reset)
        (state == S_IF) |=> (state == S_ID))
        else $error("state after S_IF is not S_ID");

    we_in_mem: assert property (@(posedge clk) disable iff (reset)
        data_we |-> (state == S_MEM))
        else $error("data_we raised outside S_MEM");

    // only a branch ends in its decode state
    ir_pc_overlap: assert property (@(posedge clk) disable iff (reset)
        (ir_load && pc_load) |-> is_branch_only)
        else $error("ir_load and pc_load high together for a non-branch");

    store_skips_wb: assert property (@(posedge clk) disable iff (reset)
        (state == S_WB) |-> !is_store)
        else $error("a store reached S_WB");

endmodule

bind mcpu_ctrl mcpu_props mcpu_props_i (.*);

//--- tests/mcpu_tb.sv
`timescale 1ns/1ps
`include "mcpu_consts.svh"

module mcpu_tb;

    logic        clk, por, soft_reset, dut_reset;
    logic [31:0] inst_sram_rdata, data_sram_rdata, inst_sram_addr;
    logic [31:0] data_sram_addr, data_sram_wdata, debug_wb_pc, debug_wb_rf_wdata;
    logic        data_sram_we;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] mregs [32];
    logic [31:0] mdmem [256];
    logic [31:0] prog [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_val [$];
    logic [4:0]  exp_reg [$];
    int          exp_gap [$];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];
    int          errors, checks, cyc, last_cyc, test_cyc, budget;
    bit          seen_write;

    mcpu_clk_gen clk_gen_i (.clk(clk), .reset(por));

    assign dut_reset = por || soft_reset;

    mcpu_top mcpu_top_i (
        .clk               (clk),
        .reset             (dut_reset),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_rdata   (data_sram_rdata),
        .inst_sram_addr    (inst_sram_addr),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // both srams answer one cycle after the address
    always @(posedge clk) begin
        inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        if (data_sram_we) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
        data_sram_rdata <= dmem[data_sram_addr[9:2]];
        cyc <= cyc + 1;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (dut_reset) begin
            if (cyc > 0 && (debug_wb_rf_we !== 4'h0 || data_sram_we !== 1'b0)) begin
                errors++;
                $display("at %0t a register or memory write happened during reset", $time);
            end
        end else begin
            if (debug_wb_rf_we !== 4'h0) begin
                if (exp_pc.size() == 0) begin
                    errors++;
                    $display("at %0t a trace write appeared with none expected", $time);
                end else begin
                    check("debug_wb_rf_we", debug_wb_rf_we, 4'hf);
                    check("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                    check("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_reg.pop_front());
                    check("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val.pop_front());
                    if (seen_write) begin
                        check("trace cycle gap", cyc - last_cyc, exp_gap[0]);
                    end
                    void'(exp_gap.pop_front());
                    seen_write = 1;
                    last_cyc = cyc;
                end
            end
            if (data_sram_we) begin
                if (st_addr.size() == 0) begin
                    errors++;
                    $display("at %0t a data write appeared with none expected", $time);
                end else begin
                    check("data_sram_addr", data_sram_addr, st_addr.pop_front());
                    check("data_sram_wdata", data_sram_wdata, st_data.pop_front());
                end
            end
        end
    end

    function automatic logic [31:0] r3(input logic [4:0] code, rd, rj, rk);
        return {6'h00, 4'h0, 2'h1, code, rk, rj, rd};
    endfunction

    function automatic logic [31:0] shi(input logic [4:0] code, rd, rj, ui5);
        return {6'h00, 4'h1, 2'h0, code, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] ri12(input logic [5:0] op6, input logic [3:0] op4,
                                         input logic [4:0] rd, rj, input logic [11:0] si);
        return {op6, op4, si, rj, rd};
    endfunction

    function automatic logic [31:0] lu12i(input logic [4:0] rd, input logic [19:0] si);
        return {6'h05, 1'b0, si, rd};
    endfunction

    function automatic logic [31:0] br16(input logic [5:0] op6, input logic [4:0] rj, rd,
                                         input logic [15:0] offs);
        return {op6, offs, rj, rd};
    endfunction

    function automatic logic [31:0] br26(input logic [5:0] op6, input logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] mem_fill(input int k);
        return (k * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    endfunction

    task automatic put_const(input logic [4:0] r);
        logic [31:0] rnd;
        rnd = $urandom;
        prog.push_back(lu12i(r, rnd[31:12]));
        prog.push_back(ri12(6'h00, 4'ha, r, r, rnd[11:0]));
    endtask

    // reference ISA model that steps until the b . self-loop
    task automatic run_model();
        logic [31:0] pc, i, a, bk, bd, v, npc, addr;
        logic [31:0] off16, off26, si12;
        logic [4:0]  rd;
        bit          wr, done;
        int          steps, gap;
        for (int k = 0; k < 32; k++) mregs[k] = 32'h0;
        pc = `MCPU_RESET_PC;
        steps = 0;
        gap = 0;
        done = 0;
        while (!done && steps < 1000) begin
            i = imem[pc[9:2]];
            rd = i[4:0];
            a = mregs[i[9:5]];
            bk = mregs[i[14:10]];
            bd = mregs[rd];
            off16 = {{14{i[25]}}, i[25:10], 2'b0};
            off26 = {{4{i[9]}}, i[9:0], i[25:10], 2'b0};
            si12 = {{20{i[21]}}, i[21:10]};
            npc = pc + 4;
            wr = 0;
            v = 0;
            steps++;
            case (i[31:26])
                6'h00: begin
                    gap += 4;
                    if (i[25:20] == 6'b000001) begin
                        wr = 1;
                        case (i[19:15])
                            5'h00: v = a + bk;
                            5'h02: v = a - bk;
                            5'h04: v = {31'b0, $signed(a) < $signed(bk)};
                            5'h05: v = {31'b0, a < bk};
                            5'h08: v = ~(a | bk);
                            5'h09: v = a & bk;
                            5'h0a: v = a | bk;
                            5'h0b: v = a ^ bk;
                            default: wr = 0;
                        endcase
                    end else if (i[25:20] == 6'b000100) begin
                        wr = 1;
                        case (i[19:15])
                            5'h01: v = a << i[14:10];
                            5'h09: v = a >> i[14:10];
                            5'h11: v = $signed(a) >>> i[14:10];
                            default: wr = 0;
                        endcase
                    end else if (i[25:22] == 4'ha) begin
                        wr = 1;
                        v = a + si12;
                    end
                end
                6'h05: begin
                    gap += 4;
                    wr = !i[25];
                    v = {i[24:5], 12'b0};
                end
                6'h0a: begin
                    addr = a + si12;
                    if (i[25:22] == 4'h2) begin
                        gap += 5;
                        wr = 1;
                        v = mdmem[addr[9:2]];
                    end else if (i[25:22] == 4'h6) begin
                        gap += 4;
                        mdmem[addr[9:2]] = bd;
                        st_addr.push_back(addr);
                        st_data.push_back(bd);
                    end else begin
                        gap += 4;
                    end
                end
                6'h13: begin
                    gap += 4;
                    wr = 1;
                    v = pc + 4;
                    npc = a + off16;
                end
                6'h14: begin
                    gap += 2;
                    npc = pc + off26;
                    done = (off26 == 0);
                end
                6'h15: begin
                    gap += 4;
                    wr = 1;
                    rd = 5'd1;
                    v = pc + 4;
                    npc = pc + off26;
                end
                6'h16: begin
                    gap += 2;
                    if (a == bd) npc = pc + off16;
                end
                6'h17: begin
                    gap += 2;
                    if (a != bd) npc = pc + off16;
                end
                default: gap += 4;  // unknown opcode, no write
            endcase
            if (wr) begin
                exp_pc.push_back(pc);
                exp_reg.push_back(rd);
                exp_val.push_back(v);
                exp_gap.push_back(gap);
                gap = 0;
                if (rd != 0) mregs[rd] = v;
            end
            pc = npc;
        end
        budget = steps * 5 + 60;
    endtask

    task automatic run_program();
        @(posedge clk);
        soft_reset <= 1'b1;
        @(negedge clk);  // memories change while the core sits in reset
        for (int k = 0; k < 256; k++) begin
            imem[k] = (k < prog.size()) ? prog[k] : 32'h0;
            dmem[k] = mem_fill(k);
            mdmem[k] = mem_fill(k);
        end
        exp_pc.delete();
        exp_reg.delete();
        exp_val.delete();
        exp_gap.delete();
        st_addr.delete();
        st_data.delete();
        seen_write = 0;
        run_model();
        test_cyc = 0;
        repeat (2) @(posedge clk);
        soft_reset <= 1'b0;
        @(negedge clk);
        check("inst_sram_addr", inst_sram_addr, `MCPU_RESET_PC);
        while (exp_pc.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);  // nothing more may be written
        if (st_addr.size() != 0) begin
            errors++;
            $display("at %0t %0d expected stores never reached the data sram", $time,
                     st_addr.size());
        end
        prog.delete();
    endtask

    task automatic alu_ops_test();
        logic [4:0] codes [8];
        codes = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b};
        for (int r = 1; r <= 6; r++) put_const(r[4:0]);
        for (int n = 0; n < 8; n++) begin
            prog.push_back(r3(codes[n], 5'(7 + n), 5'(1 + $urandom % 6), 5'(1 + $urandom % 6)));
        end
        prog.push_back(r3(5'h00, 5'd0, 5'd1, 5'd2));  // r0 write dropped
        prog.push_back(r3(5'h0a, 5'd20, 5'd0, 5'd0));
        prog.push_back(ri12(6'h00, 4'ha, 5'd21, 5'd0, 12'(($urandom))));
        prog.push_back(br26(6'h14, 26'd0));
        run_program();
    endtask

    task automatic shift_test();
        logic [4:0] codes [3];
        codes = '{5'h01, 5'h09, 5'h11};
        for (int r = 1; r <= 4; r++) put_const(r[4:0]);
        prog.push_back(lu12i(5'd5, 20'h80000 | 20'($urandom)));  // negative source
        for (int n = 0; n < 9; n++) begin
            prog.push_back(shi(codes[n % 3], 5'(6 + n), 5'(1 + $urandom % 5), 5'($urandom)));
        end
        prog.push_back(shi(5'h11, 5'd16, 5'd5, 5'd31));
        prog.push_back(br26(6'h14, 26'd0));
        run_program();
    endtask

    task automatic load_store_test();
        prog.push_back(lu12i(5'd1, 20'h0));
        prog.push_back(ri12(6'h00, 4'ha, 5'd1, 5'd1, 12'h100));
        for (int r = 2; r <= 4; r++) put_const(r[4:0]);
        prog.push_back(ri12(6'h0a, 4'h6, 5'd2, 5'd1, 12'h000));
        prog.push_back(ri12(6'h0a, 4'h6, 5'd3, 5'd1, 12'h008));
        prog.push_back(ri12(6'h0a, 4'h2, 5'd5, 5'd1, 12'h000));
        prog.push_back(ri12(6'h0a, 4'h2, 5'd6, 5'd1, 12'h008));
        prog.push_back(ri12(6'h0a, 4'h6, 5'd4, 5'd1, 12'hffc));
        prog.push_back(ri12(6'h0a, 4'h2, 5'd7, 5'd1, 12'hffc));
        prog.push_back(ri12(6'h0a, 4'h2, 5'd8, 5'd1, 12'h004));  // untouched fill word
        prog.push_back(br26(6'h14, 26'd0));
        run_program();
    endtask

    task automatic branch_test();
        put_const(5'd1);
        prog.push_back(ri12(6'h00, 4'ha, 5'd2, 5'd1, 12'h000));
        prog.push_back(ri12(6'h00, 4'ha, 5'd3, 5'd1, 12'h001));
        prog.push_back(br16(6'h16, 5'd1, 5'd2, 16'd2));  // beq taken
        prog.push_back(ri12(6'h00, 4'ha, 5'd4, 5'd0, 12'h001));
        prog.push_back(br16(6'h16, 5'd1, 5'd3, 16'd2));  // beq not taken
        prog.push_back(ri12(6'h00, 4'ha, 5'd5, 5'd0, 12'h002));
        prog.push_back(br16(6'h17, 5'd1, 5'd3, 16'd2));  // bne taken
        prog.push_back(ri12(6'h00, 4'ha, 5'd6, 5'd0, 12'h003));
        prog.push_back(br16(6'h17, 5'd1, 5'd2, 16'd2));  // bne not taken
        prog.push_back(ri12(6'h00, 4'ha, 5'd7, 5'd0, 12'h004));
        prog.push_back(br26(6'h14, 26'd2));
        prog.push_back(ri12(6'h00, 4'ha, 5'd8, 5'd0, 12'h005));
        prog.push_back(br26(6'h15, 26'd2));              // bl links to r1
        prog.push_back(ri12(6'h00, 4'ha, 5'd9, 5'd0, 12'h006));
        prog.push_back(br16(6'h13, 5'd1, 5'd10, 16'd3)); // jirl off the bl link
        prog.push_back(ri12(6'h00, 4'ha, 5'd11, 5'd0, 12'h007));
        prog.push_back(r3(5'h00, 5'd12, 5'd10, 5'd1));
        prog.push_back(br26(6'h14, 26'd0));
        run_program();
    endtask

    initial begin
        void'($urandom(32'ha48a_586e));
        soft_reset = 1'b0;
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        errors = 0;
        checks = 0;
        cyc = 0;
        last_cyc = 0;
        test_cyc = 0;
        budget = 1000;
        alu_ops_test();
        shift_test();
        load_store_test();
        branch_test();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // per-program budget from the model's instruction count
    initial begin
        while (test_cyc <= budget) begin
            @(posedge clk);
            test_cyc = test_cyc + 1;
        end
        $display("timeout: program did not finish within %0d cycles", budget);
        $display("checks %0d, errors %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule
